//--- Makefile
VERILATOR ?= verilator
TOP       ?= memSubsystem_tb
FILELIST  ?= memSubsystem.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- byteSequencer.sv
module byteSequencer import memTypesPkg::*, memCtrlPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       flush,
  input  logic       start,
  input  memReqT     curReq,
  output ramBusT     ramOut,
  output logic       capEn,
  output logic [1:0] capIdx,
  output logic       finish
);

  seqStateT state;

  // request being stepped, latched on start
  memReqT req;

  // bytes already put on the bus, 1 to len while busy
  lenT stage;
  lenT prevStage;

  assign prevStage = stage - 3'd1;

  // byte 0 goes out straight from curReq in the start cycle
  // later bytes come from the latched copy
  always_comb begin
    if (state == seqIdle) begin
      ramOut.we    = start && curReq.write;
      ramOut.addr  = curReq.addr;
      ramOut.wdata = curReq.wdata[7:0];
    end else begin
      ramOut.we    = req.write && (stage != req.len);
      ramOut.addr  = req.addr + addrT'(stage);
      ramOut.wdata = req.wdata[{stage[1:0], 3'b000} +: 8];
    end
  end

  // read data lags the address by one cycle
  assign capEn  = (state == seqBusy) && !req.write;
  assign capIdx = prevStage[1:0];

  // last byte arrives, a flush cancels the done
  assign finish = (state == seqBusy) && (stage == req.len) && !flush;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      state <= seqIdle;
      stage <= '0;
    end else begin
      case (state)
        seqIdle: begin
          if (start) begin
            state <= seqBusy;
            stage <= 3'd1;
          end
        end
        seqBusy: begin
          if (finish) begin
            state <= seqIdle;
          end else begin
            stage <= stage + 3'd1;
          end
        end
        default: state <= seqIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      req <= curReq;
    end
  end

endmodule

//--- icache.sv
module icache import memTypesPkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic fetchEn,
  input  addrT fetchAddr,
  input  logic instOutEn,
  input  wordT instWord,
  input  addrT fillAddr,
  output logic instReady,
  output wordT instOut,
  output logic memFetchEn,
  output addrT memFetchAddr
);

  // direct mapped storage, one word per line
  wordT lineData [cacheLines];
  tagT  lineTag [cacheLines];
  logic [cacheLines-1:0] lineValid;

  indexT fetchIdx;
  tagT   fetchTag;
  indexT fillIdx;
  logic  hit;
  logic  fillOk;

  assign fetchIdx = fetchAddr[8:2];
  assign fetchTag = fetchAddr[17:9];
  assign fillIdx  = fillAddr[8:2];

  // same-cycle lookup
  assign hit = fetchEn && lineValid[fetchIdx] && (lineTag[fetchIdx] == fetchTag);

  // refill word from the controller wins over the array
  assign instReady = hit || instOutEn;
  assign instOut   = instOutEn ? instWord : lineData[fetchIdx];

  // only misses go out to the controller
  assign memFetchEn   = fetchEn && !hit;
  assign memFetchAddr = fetchAddr;

  // I/O space is never allocated
  assign fillOk = instOutEn && (fillAddr[17:16] != ioRegion);

  always_ff @(posedge clk) begin
    if (rst) begin
      lineValid <= '0;
    end else if (fillOk) begin
      lineValid[fillIdx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fillOk) begin
      lineData[fillIdx] <= instWord;
      lineTag[fillIdx]  <= fillAddr[17:9];
    end
  end

endmodule

//--- memArbiter.sv
module memArbiter import memTypesPkg::*, memCtrlPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   flush,
  input  logic   memFetchEn,
  input  addrT   memFetchAddr,
  input  logic   lsEn,
  input  memReqT lsReq,
  input  logic   finish,
  output logic   start,
  output memReqT curReq,
  output portT   curPort
);

  // one waiting slot per port
  memReqT instPend;
  memReqT lsPend;
  logic   instValid;
  logic   lsValid;

  // a transfer is running on the RAM
  logic active;

  memReqT fetchReq;
  logic   free;
  logic   takeLsSlot;
  logic   takeInstSlot;
  logic   takeLsNew;
  logic   takeInstNew;
  logic   issue;

  // a fetch is a plain word read
  assign fetchReq = '{write: 1'b0, addr: memFetchAddr, len: wordLen, wdata: '0};

  // idle, or the running transfer ends this cycle
  assign free = !active || finish;

  // ls slot, inst slot, then new ls, then new fetch
  always_comb begin
    takeLsSlot   = free && lsValid;
    takeInstSlot = free && !lsValid && instValid;
    takeLsNew    = free && !lsValid && !instValid && lsEn;
    takeInstNew  = free && !lsValid && !instValid && !lsEn && memFetchEn;
    issue        = takeLsSlot || takeInstSlot || takeLsNew || takeInstNew;
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      active    <= 1'b0;
      start     <= 1'b0;
      instValid <= 1'b0;
      lsValid   <= 1'b0;
    end else begin
      // start is a one-cycle strobe
      start <= issue;
      if (issue) begin
        active <= 1'b1;
      end else if (finish) begin
        active <= 1'b0;
      end
      // a strobe that is not served at once waits in its slot
      lsValid   <= (lsValid && !takeLsSlot) || (lsEn && !takeLsNew);
      instValid <= (instValid && !takeInstSlot) || (memFetchEn && !takeInstNew);
    end
  end

  always_ff @(posedge clk) begin
    if (lsEn) begin
      lsPend <= lsReq;
    end
    if (memFetchEn) begin
      instPend <= fetchReq;
    end
    if (takeLsSlot) begin
      curReq  <= lsPend;
      curPort <= lsPort;
    end else if (takeInstSlot) begin
      curReq  <= instPend;
      curPort <= instPort;
    end else if (takeLsNew) begin
      curReq  <= lsReq;
      curPort <= lsPort;
    end else if (takeInstNew) begin
      curReq  <= fetchReq;
      curPort <= instPort;
    end
  end

endmodule

//--- memCtrlPkg.sv
package memCtrlPkg;
  import memTypesPkg::*;

  // owner of a transfer
  typedef enum logic {
    instPort,
    lsPort
  } portT;

  // byte sequencer FSM
  typedef enum logic {
    seqIdle,
    seqBusy
  } seqStateT;

  // one queued or running request, 54 bits
  // fetches are reads with len = wordLen
  typedef struct packed {
    logic write;
    addrT addr;
    lenT  len;
    wordT wdata;
  } memReqT;

  // drive toward the RAM, 27 bits
  // address is registered by the RAM at the rising edge
  typedef struct packed {
    logic we;
    addrT addr;
    byteT wdata;
  } ramBusT;

endpackage

//--- memSubsystem.f
memTypesPkg.sv
memCtrlPkg.sv
icache.sv
memArbiter.sv
byteSequencer.sv
resultAssembler.sv
memSubsystem.sv
memSubsystem_assertions.sv
memSubsystem_tb.sv

//--- memSubsystem.sv
module memSubsystem import memTypesPkg::*, memCtrlPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   flush,
  input  logic   fetchEn,
  input  addrT   fetchAddr,
  output logic   instReady,
  output wordT   instOut,
  input  logic   lsEn,
  input  memReqT lsReq,
  output logic   lsDone,
  output wordT   ldData,
  output ramBusT ramOut,
  input  byteT   ramData
);

  // cache miss path
  logic memFetchEn;
  addrT memFetchAddr;

  // arbiter to sequencer and assembler
  logic   start;
  memReqT curReq;
  portT   curPort;

  // sequencer to assembler
  logic       capEn;
  logic [1:0] capIdx;
  logic       finish;

  // refill back into the cache
  logic instOutEn;
  wordT instWord;
  addrT fillAddr;

  icache uIcache (
    .clk(clk), .rst(rst), .fetchEn(fetchEn), .fetchAddr(fetchAddr),
    .instOutEn(instOutEn), .instWord(instWord), .fillAddr(fillAddr),
    .instReady(instReady), .instOut(instOut),
    .memFetchEn(memFetchEn), .memFetchAddr(memFetchAddr)
  );

  memArbiter uArbiter (
    .clk(clk), .rst(rst), .flush(flush),
    .memFetchEn(memFetchEn), .memFetchAddr(memFetchAddr),
    .lsEn(lsEn), .lsReq(lsReq), .finish(finish),
    .start(start), .curReq(curReq), .curPort(curPort)
  );

  byteSequencer uSequencer (
    .clk(clk), .rst(rst), .flush(flush), .start(start), .curReq(curReq),
    .ramOut(ramOut), .capEn(capEn), .capIdx(capIdx), .finish(finish)
  );

  resultAssembler uAssembler (
    .clk(clk), .rst(rst), .start(start), .curReq(curReq), .curPort(curPort),
    .ramData(ramData), .capEn(capEn), .capIdx(capIdx), .finish(finish),
    .instOutEn(instOutEn), .instWord(instWord), .fillAddr(fillAddr),
    .lsDone(lsDone), .ldData(ldData)
  );

endmodule

//--- memSubsystem_assertions.sv
module memSubsystem_assertions import memCtrlPkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     flush,
  input logic     start,
  input logic     finish,
  input seqStateT state,
  input ramBusT   ramOut
);

  // a started transfer not yet finished or flushed
  logic inFlight;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      inFlight <= 1'b0;
    end else if (start) begin
      inFlight <= 1'b1;
    end else if (finish) begin
      inFlight <= 1'b0;
    end
  end

  // done only out of a transfer the sequencer took on
  finishBusy: assert property (@(posedge clk) disable iff (rst) finish |-> inFlight)
    else $error("finish raised without a started transfer");

  // no new start in the middle of a transfer
  startGap: assert property (@(posedge clk) disable iff (rst)
    (state == seqBusy && !finish) |=> !start)
    else $error("start raised during an active transfer");

  // RAM write enable quiet right after reset
  weAfterReset: assert property (@(posedge clk) rst |=> !ramOut.we)
    else $error("we high one cycle after reset");

endmodule

bind byteSequencer memSubsystem_assertions uSeqChecks (
  .clk(clk), .rst(rst), .flush(flush), .start(start), .finish(finish), .state(state),
  .ramOut(ramOut)
);

//--- memSubsystem_tb.sv
module memSubsystem_tb import memTypesPkg::*, memCtrlPkg::*; ();

  // longest wait for any strobe, in cycles
  localparam int maxWait = 40;
  // done strobe comes len+1 edges after the edge that takes the request
  localparam int missLatency = int'(wordLen) + 1;

  logic   clk;
  logic   rst;
  logic   flush;
  logic   fetchEn;
  addrT   fetchAddr;
  logic   instReady;
  wordT   instOut;
  logic   lsEn;
  memReqT lsReq;
  logic   lsDone;
  wordT   ldData;
  ramBusT ramOut;
  byteT   ramData = '0;

  // 256 KiB byte RAM and the expected contents
  byteT ram [262144];
  byteT shadow [262144];

  int seed;
  int errors;
  int testErrors;
  int tests;

  memSubsystem UUT (
    .clk(clk), .rst(rst), .flush(flush),
    .fetchEn(fetchEn), .fetchAddr(fetchAddr), .instReady(instReady), .instOut(instOut),
    .lsEn(lsEn), .lsReq(lsReq), .lsDone(lsDone), .ldData(ldData),
    .ramOut(ramOut), .ramData(ramData)
  );

  always #2 clk = ~clk;

  // address taken at the edge, byte shows up the cycle after
  always @(posedge clk) begin
    if (ramOut.we) begin
      ram[ramOut.addr] <= ramOut.wdata;
    end
    ramData <= ram[ramOut.addr];
  end

  // little-endian, bytes beyond count read as zero
  function automatic wordT expectedWord(addrT a, lenT count);
    wordT w;
    w = '0;
    for (int i = 0; i < int'(count); i++) begin
      w[i*8 +: 8] = shadow[a + addrT'(i)];
    end
    return w;
  endfunction

  task automatic checkWord(string name, wordT got, wordT exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      testErrors++;
    end
  endtask

  task automatic checkFlag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      testErrors++;
    end
  endtask

  task automatic noteProblem(string what);
    $display("problem at %0t: %s", $time, what);
    testErrors++;
  endtask

  task automatic closeTest(string name);
    if (testErrors == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, testErrors);
    end
    errors += testErrors;
    testErrors = 0;
    tests++;
  endtask

  // one fetch pulse, lat counts edges after the one that samples fetchEn
  // a hit reports lat 0
  task automatic fetchWord(addrT a, output wordT word, output int lat, output logic seen);
    seen = 1'b0;
    lat = 0;
    word = '0;
    fetchAddr = a;
    fetchEn = 1'b1;
    @(negedge clk);
    if (instReady) begin
      seen = 1'b1;
      word = instOut;
    end
    @(posedge clk);
    #1;
    fetchEn = 1'b0;
    while (!seen && lat < maxWait) begin
      @(negedge clk);
      if (instReady) begin
        seen = 1'b1;
        word = instOut;
      end else begin
        @(posedge clk);
        #1;
        lat++;
      end
    end
    if (!seen) begin
      noteProblem("instReady never came for a fetch");
    end
    @(posedge clk);
    #1;
  endtask

  // one load/store pulse, waits for lsDone
  task automatic lsAccess(logic isWrite, addrT a, lenT count, wordT data,
                          output wordT result, output logic seen);
    int waited;
    waited = 0;
    seen = 1'b0;
    result = '0;
    lsReq = '{write: isWrite, addr: a, len: count, wdata: data};
    lsEn = 1'b1;
    @(posedge clk);
    #1;
    lsEn = 1'b0;
    while (!seen && waited < maxWait) begin
      @(negedge clk);
      if (lsDone) begin
        seen = 1'b1;
        result = ldData;
      end else begin
        @(posedge clk);
        #1;
        waited++;
      end
    end
    if (!seen) begin
      noteProblem("lsDone never came for a load/store");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic fetchTest();
    wordT word;
    int lat;
    logic seen;
    // cold miss, then the refilled line hits
    fetchWord(18'h00100, word, lat, seen);
    checkWord("miss latency", wordT'(lat), wordT'(missLatency));
    checkWord("instOut", word, expectedWord(18'h00100, wordLen));
    fetchWord(18'h00100, word, lat, seen);
    checkFlag("instReady same cycle", logic'(lat == 0), 1'b1);
    checkWord("instOut", word, expectedWord(18'h00100, wordLen));
    closeTest("fetchTest");
  endtask

  task automatic lsWriteReadTest();
    wordT data;
    wordT word;
    logic seen;
    data = $random(seed);
    lsAccess(1'b1, 18'h01230, 3'd4, data, word, seen);
    for (int i = 0; i < 4; i++) begin
      shadow[18'h01230 + addrT'(i)] = data[i*8 +: 8];
    end
    // bytes land little-endian in the RAM
    checkWord("ram bytes", {ram[18'h01233], ram[18'h01232], ram[18'h01231], ram[18'h01230]},
              data);
    lsAccess(1'b0, 18'h01230, 3'd4, '0, word, seen);
    checkWord("ldData", word, expectedWord(18'h01230, 3'd4));
    closeTest("lsWriteReadTest");
  endtask

  task automatic shortLoadTest();
    wordT word;
    logic seen;
    lsAccess(1'b0, 18'h02345, 3'd1, '0, word, seen);
    checkWord("ldData byte", word, expectedWord(18'h02345, 3'd1));
    // unaligned half word
    lsAccess(1'b0, 18'h02347, 3'd2, '0, word, seen);
    checkWord("ldData half", word, expectedWord(18'h02347, 3'd2));
    closeTest("shortLoadTest");
  endtask

  task automatic priorityTest();
    wordT lsWord;
    wordT iWord;
    int cyc;
    int lsAt;
    int instAt;
    cyc = 0;
    lsAt = -1;
    instAt = -1;
    lsWord = '0;
    iWord = '0;
    // both ports in the same idle cycle
    fetchAddr = 18'h00204;
    fetchEn = 1'b1;
    lsReq = '{write: 1'b0, addr: 18'h01800, len: 3'd4, wdata: '0};
    lsEn = 1'b1;
    @(posedge clk);
    #1;
    fetchEn = 1'b0;
    lsEn = 1'b0;
    while ((lsAt < 0 || instAt < 0) && cyc < 2 * maxWait) begin
      @(negedge clk);
      if (lsDone && lsAt < 0) begin
        lsAt = cyc;
        lsWord = ldData;
      end
      if (instReady && instAt < 0) begin
        instAt = cyc;
        iWord = instOut;
      end
      @(posedge clk);
      #1;
      cyc++;
    end
    if (lsAt < 0 || instAt < 0) begin
      noteProblem("both done strobes did not arrive");
    end else begin
      checkFlag("lsDone before instReady", logic'(lsAt < instAt), 1'b1);
      checkWord("ldData", lsWord, expectedWord(18'h01800, 3'd4));
      checkWord("instOut", iWord, expectedWord(18'h00204, wordLen));
    end
    closeTest("priorityTest");
  endtask

  task automatic ioNoCacheTest();
    wordT word;
    int lat;
    logic seen;
    // bits 17:16 == 3, never allocated
    for (int i = 0; i < 2; i++) begin
      fetchWord(18'h30040, word, lat, seen);
      checkWord("io fetch latency", wordT'(lat), wordT'(missLatency));
      checkWord("instOut", word, expectedWord(18'h30040, wordLen));
    end
    closeTest("ioNoCacheTest");
  endtask

  task automatic flushTest();
    wordT word;
    int lat;
    logic seen;
    seen = 1'b0;
    fetchAddr = 18'h00408;
    fetchEn = 1'b1;
    @(posedge clk);
    #1;
    fetchEn = 1'b0;
    // mispredict while the miss is on the RAM
    @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    for (int i = 0; i < maxWait; i++) begin
      @(negedge clk);
      if (instReady) begin
        seen = 1'b1;
      end
      @(posedge clk);
      #1;
    end
    checkFlag("instReady after flush", seen, 1'b0);
    // reissued fetch still misses
    fetchWord(18'h00408, word, lat, seen);
    checkWord("miss latency", wordT'(lat), wordT'(missLatency));
    checkWord("instOut", word, expectedWord(18'h00408, wordLen));
    closeTest("flushTest");
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    flush = 1'b0;
    fetchEn = 1'b0;
    fetchAddr = '0;
    lsEn = 1'b0;
    lsReq = '0;
    errors = 0;
    testErrors = 0;
    tests = 0;
    seed = 32'ha97fbfe9;
    for (int i = 0; i < 262144; i++) begin
      ram[i] = 8'($random(seed));
      shadow[i] = ram[i];
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    fetchTest();
    lsWriteReadTest();
    shortLoadTest();
    priorityTest();
    ioNoCacheTest();
    flushTest();
    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- memTypesPkg.sv
package memTypesPkg;

  // byte address into the 256 KiB space
  typedef logic [17:0] addrT;

  // instruction or load/store data word
  typedef logic [31:0] wordT;

  // one RAM data unit, the RAM is byte wide
  typedef logic [7:0] byteT;

  // byte count of one transfer
  // legal values are 1, 2 and 4
  typedef logic [2:0] lenT;

  // cache tag, address bits 17:9
  typedef logic [8:0] tagT;

  // cache index, address bits 8:2
  typedef logic [6:0] indexT;

  // 512 bytes of cache, one word per line
  localparam int cacheLines = 128;

  // address bits 17:16 of the I/O window
  // never cached
  localparam logic [1:0] ioRegion = 2'd3;

  // an instruction fetch always reads a full word
  localparam lenT wordLen = 3'd4;

endpackage

//--- resultAssembler.sv
module resultAssembler import memTypesPkg::*, memCtrlPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  memReqT     curReq,
  input  portT       curPort,
  input  byteT       ramData,
  input  logic       capEn,
  input  logic [1:0] capIdx,
  input  logic       finish,
  output logic       instOutEn,
  output wordT       instWord,
  output addrT       fillAddr,
  output logic       lsDone,
  output wordT       ldData
);

  // owner of the transfer under build
  portT port;

  // little-endian word, upper lanes stay zero on short loads
  wordT buildWord;
  wordT mergeWord;

  // last byte is folded in on the fly
  always_comb begin
    mergeWord = buildWord;
    if (capEn) begin
      mergeWord[{capIdx, 3'b000} +: 8] = ramData;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      port      <= instPort;
      instOutEn <= 1'b0;
      lsDone    <= 1'b0;
    end else begin
      if (start) begin
        port <= curPort;
      end
      instOutEn <= finish && (port == instPort);
      lsDone    <= finish && (port == lsPort);
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      buildWord <= '0;
      // refill address for the cache
      if (curPort == instPort) begin
        fillAddr <= curReq.addr;
      end
    end else begin
      buildWord <= mergeWord;
    end
    // result held until the next transfer of the same port
    if (finish) begin
      if (port == instPort) begin
        instWord <= mergeWord;
      end else begin
        ldData <= mergeWord;
      end
    end
  end

endmodule
